//--- source/backing_mem.sv
`timescale 1ns/100ps

module backing_mem #(
	parameter ADDR_WIDTH = 12
)(
	input										clock,
	input										reset,
	input [ADDR_WIDTH-1:0]						mem_addr,
	input										mem_write,
	input [dcache_pkg::DATA_WIDTH-1:0]			mem_write_data,
	output logic [dcache_pkg::DATA_WIDTH-1:0]	mem_read_data
);

	localparam DEPTH = 2 ** (ADDR_WIDTH - 2);

	logic [dcache_pkg::DATA_WIDTH-1:0]	words [DEPTH];
	logic [ADDR_WIDTH-3:0]				word_index;

	// byte address to word index
	assign word_index = mem_addr[ADDR_WIDTH-1:2];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < DEPTH; i++)
				words[i] <= '0;
		end
		else if (mem_write)
		begin
			words[word_index] <= mem_write_data;
		end
	end

	// read registered every cycle
	always_ff @(posedge clock)
	begin
		mem_read_data <= words[word_index];
	end

endmodule

//--- source/dcache_controller.sv
`timescale 1ns/100ps

module dcache_controller #(
	parameter ADDR_WIDTH = 12
)(
	input										clock,
	input										reset,
	// AXI4-Lite slave
	input [ADDR_WIDTH-1:0]						awaddr,
	input										awvalid,
	output logic								awready,
	input [dcache_pkg::DATA_WIDTH-1:0]			wdata,
	input										wvalid,
	output logic								wready,
	output logic [1:0]							bresp,
	output logic								bvalid,
	input										bready,
	input [ADDR_WIDTH-1:0]						araddr,
	input										arvalid,
	output logic								arready,
	output logic [dcache_pkg::DATA_WIDTH-1:0]	rdata,
	output logic [1:0]							rresp,
	output logic								rvalid,
	input										rready,
	// cache storage
	output logic [ADDR_WIDTH-1:0]				addr,
	output logic								lookup,
	output logic								write_hit,
	output logic								install,
	output logic								install_dirty,
	output logic [dcache_pkg::DATA_WIDTH-1:0]	install_data,
	input										hit,
	input [dcache_pkg::DATA_WIDTH-1:0]			hit_data,
	input										victim_dirty,
	input [ADDR_WIDTH-1:0]						victim_addr,
	input [dcache_pkg::DATA_WIDTH-1:0]			victim_data,
	// latency timer
	output logic								start,
	input										done,
	// backing memory
	output logic [ADDR_WIDTH-1:0]				mem_addr,
	output logic								mem_write,
	output logic [dcache_pkg::DATA_WIDTH-1:0]	mem_write_data,
	input [dcache_pkg::DATA_WIDTH-1:0]			mem_read_data
);

	dcache_pkg::ctrl_state_t				state;
	logic									req_write;
	logic [dcache_pkg::DATA_WIDTH-1:0]		req_wdata;
	logic									misaligned;
	logic									to_respond;
	logic [1:0]								resp_code;
	logic [dcache_pkg::DATA_WIDTH-1:0]		resp_data;

	assign misaligned = (addr[1:0] != 2'b00);

	// misaligned requests never touch the storage
	assign lookup    = (state == dcache_pkg::ST_LOOKUP) && !misaligned;
	assign write_hit = lookup && req_write && hit;

	always_comb
	begin
		case (state)
			dcache_pkg::ST_LOOKUP:    install = lookup && !hit && req_write && !victim_dirty;
			dcache_pkg::ST_WRITEBACK: install = done && req_write;
			dcache_pkg::ST_REFILL:    install = done;
			default:                  install = 1'b0;
		endcase
	end

	// writes install dirty, refills install clean
	assign install_dirty = req_write;
	assign install_data  = req_write ? req_wdata : mem_read_data;

	// the request is finished this cycle
	assign to_respond = ((state == dcache_pkg::ST_LOOKUP) &&
	                     (misaligned || hit || (req_write && !victim_dirty))) ||
	                    ((state == dcache_pkg::ST_WRITEBACK) && done && req_write) ||
	                    ((state == dcache_pkg::ST_REFILL) && done);

	assign resp_code = ((state == dcache_pkg::ST_LOOKUP) && misaligned) ?
	                   dcache_pkg::RESP_SLVERR : dcache_pkg::RESP_OKAY;

	always_comb
	begin
		if (state != dcache_pkg::ST_LOOKUP)
			resp_data = mem_read_data;
		else if (misaligned)
			resp_data = '0;
		else
			resp_data = hit_data;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state     <= dcache_pkg::ST_IDLE;
			arready   <= 1'b0;
			awready   <= 1'b0;
			wready    <= 1'b0;
			bvalid    <= 1'b0;
			rvalid    <= 1'b0;
			start     <= 1'b0;
			mem_write <= 1'b0;
			req_write <= 1'b0;
		end
		else
		begin
			start     <= 1'b0;
			mem_write <= 1'b0;
			if (to_respond)
			begin
				state  <= dcache_pkg::ST_RESPOND;
				rvalid <= !req_write;
				bvalid <= req_write;
				rresp  <= resp_code;
				bresp  <= resp_code;
				rdata  <= resp_data;
			end
			else
			begin
				case (state)
					dcache_pkg::ST_IDLE:
					begin
						if (arvalid && arready)
						begin
							addr      <= araddr;
							req_write <= 1'b0;
							arready   <= 1'b0;
							state     <= dcache_pkg::ST_LOOKUP;
						end
						else if (awvalid && awready && wvalid && wready)
						begin
							addr      <= awaddr;
							req_wdata <= wdata;
							req_write <= 1'b1;
							awready   <= 1'b0;
							wready    <= 1'b0;
							state     <= dcache_pkg::ST_LOOKUP;
						end
						else
						begin
							// reads win when both are pending
							arready <= arvalid;
							awready <= awvalid && wvalid && !arvalid;
							wready  <= awvalid && wvalid && !arvalid;
						end
					end
					dcache_pkg::ST_LOOKUP:
					begin
						start <= 1'b1;
						if (victim_dirty)
						begin
							mem_addr       <= victim_addr;
							mem_write_data <= victim_data;
							mem_write      <= 1'b1;
							state          <= dcache_pkg::ST_WRITEBACK;
						end
						else
						begin
							mem_addr <= addr;
							state    <= dcache_pkg::ST_REFILL;
						end
					end
					dcache_pkg::ST_WRITEBACK:
					begin
						// only a read miss gets here with done
						if (done)
						begin
							start    <= 1'b1;
							mem_addr <= addr;
							state    <= dcache_pkg::ST_REFILL;
						end
					end
					dcache_pkg::ST_RESPOND:
					begin
						if ((rvalid && rready) || (bvalid && bready))
						begin
							rvalid <= 1'b0;
							bvalid <= 1'b0;
							state  <= dcache_pkg::ST_IDLE;
						end
					end
					default:
					begin
						state <= state;
					end
				endcase
			end
		end
	end

endmodule

//--- source/dcache_mem.sv
`timescale 1ns/100ps

module dcache_mem #(
	parameter ADDR_WIDTH = 12,
	parameter NUM_SETS   = 8
)(
	input										clock,
	input										reset,
	// request from the controller
	input [ADDR_WIDTH-1:0]						addr,
	input										lookup,
	input										write_hit,
	input										install,
	input										install_dirty,
	input [dcache_pkg::DATA_WIDTH-1:0]			install_data,
	// lookup results for the addressed set
	output logic								hit,
	output logic [dcache_pkg::DATA_WIDTH-1:0]	hit_data,
	output logic								victim_dirty,
	output logic [ADDR_WIDTH-1:0]				victim_addr,
	output logic [dcache_pkg::DATA_WIDTH-1:0]	victim_data
);

	localparam INDEX_WIDTH = $clog2(NUM_SETS);
	localparam TAG_WIDTH   = ADDR_WIDTH - 2 - INDEX_WIDTH;

	// tag and data arrays, two ways per set
	logic [TAG_WIDTH-1:0]					tag_mem [NUM_SETS][2];
	logic [dcache_pkg::DATA_WIDTH-1:0]		data_mem [NUM_SETS][2];

	logic [NUM_SETS-1:0][1:0]				valid_bits;
	logic [NUM_SETS-1:0][1:0]				dirty_bits;
	// per set, the way to replace next
	logic [NUM_SETS-1:0]					lru;

	logic [INDEX_WIDTH-1:0]					index;
	logic [TAG_WIDTH-1:0]					tag;
	logic									hit_way0;
	logic									hit_way1;
	logic									hit_way;
	logic									victim_way;

	// word address split with the byte offset dropped
	assign index = addr[INDEX_WIDTH+1:2];
	assign tag   = addr[ADDR_WIDTH-1:INDEX_WIDTH+2];

	assign hit_way0 = valid_bits[index][0] && (tag_mem[index][0] == tag);
	assign hit_way1 = valid_bits[index][1] && (tag_mem[index][1] == tag);
	assign hit      = hit_way0 || hit_way1;
	assign hit_way  = hit_way1;
	assign hit_data = data_mem[index][hit_way];

	assign victim_way = lru[index];
	// an invalid victim never needs a writeback
	assign victim_dirty = valid_bits[index][victim_way] && dirty_bits[index][victim_way];
	assign victim_addr  = {tag_mem[index][victim_way], index, 2'b00};
	assign victim_data  = data_mem[index][victim_way];

	// word and tag storage
	always_ff @(posedge clock)
	begin
		if (write_hit)
		begin
			data_mem[index][hit_way] <= install_data;
		end
		else if (install)
		begin
			data_mem[index][victim_way] <= install_data;
			tag_mem[index][victim_way]  <= tag;
		end
	end

	// line state and replacement
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid_bits <= '0;
			dirty_bits <= '0;
			lru        <= '0;
		end
		else
		begin
			if (write_hit)
			begin
				dirty_bits[index][hit_way] <= 1'b1;
			end
			else if (install)
			begin
				valid_bits[index][victim_way] <= 1'b1;
				dirty_bits[index][victim_way] <= install_dirty;
			end

			// the way just used becomes most recent
			if ((lookup || write_hit) && hit)
			begin
				lru[index] <= ~hit_way;
			end
			else if (install)
			begin
				lru[index] <= ~victim_way;
			end
		end
	end

endmodule

//--- source/dcache_pkg.sv
package dcache_pkg;

	// width of one cached word
	localparam int DATA_WIDTH = 32;

	// AXI response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// controller FSM states
	typedef enum logic [2:0]
	{
		ST_IDLE,
		// resolve hit or miss for the latched request
		ST_LOOKUP,
		// dirty victim going out to backing memory
		ST_WRITEBACK,
		// read miss waiting on backing memory
		ST_REFILL,
		// response held until the master takes it
		ST_RESPOND
	} ctrl_state_t;

endpackage

//--- source/dcache_top.sv
`timescale 1ns/100ps

module dcache_top #(
	parameter ADDR_WIDTH  = 12,
	parameter NUM_SETS    = 8,
	parameter MEM_LATENCY = 4
)(
	input										clock,
	input										reset,
	input [ADDR_WIDTH-1:0]						awaddr,
	input										awvalid,
	output logic								awready,
	input [dcache_pkg::DATA_WIDTH-1:0]			wdata,
	input										wvalid,
	output logic								wready,
	output logic [1:0]							bresp,
	output logic								bvalid,
	input										bready,
	input [ADDR_WIDTH-1:0]						araddr,
	input										arvalid,
	output logic								arready,
	output logic [dcache_pkg::DATA_WIDTH-1:0]	rdata,
	output logic [1:0]							rresp,
	output logic								rvalid,
	input										rready
);

	// controller to cache storage
	logic [ADDR_WIDTH-1:0]				addr;
	logic								lookup;
	logic								write_hit;
	logic								install;
	logic								install_dirty;
	logic [dcache_pkg::DATA_WIDTH-1:0]	install_data;
	logic								hit;
	logic [dcache_pkg::DATA_WIDTH-1:0]	hit_data;
	logic								victim_dirty;
	logic [ADDR_WIDTH-1:0]				victim_addr;
	logic [dcache_pkg::DATA_WIDTH-1:0]	victim_data;

	// timer and backing memory
	logic								start;
	logic								done;
	logic [ADDR_WIDTH-1:0]				mem_addr;
	logic								mem_write;
	logic [dcache_pkg::DATA_WIDTH-1:0]	mem_write_data;
	logic [dcache_pkg::DATA_WIDTH-1:0]	mem_read_data;

	dcache_controller #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) i_dcache_controller (
		.clock(clock),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.addr(addr),
		.lookup(lookup),
		.write_hit(write_hit),
		.install(install),
		.install_dirty(install_dirty),
		.install_data(install_data),
		.hit(hit),
		.hit_data(hit_data),
		.victim_dirty(victim_dirty),
		.victim_addr(victim_addr),
		.victim_data(victim_data),
		.start(start),
		.done(done),
		.mem_addr(mem_addr),
		.mem_write(mem_write),
		.mem_write_data(mem_write_data),
		.mem_read_data(mem_read_data)
	);

	dcache_mem #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.NUM_SETS(NUM_SETS)
	) i_dcache_mem (
		.clock(clock),
		.reset(reset),
		.addr(addr),
		.lookup(lookup),
		.write_hit(write_hit),
		.install(install),
		.install_dirty(install_dirty),
		.install_data(install_data),
		.hit(hit),
		.hit_data(hit_data),
		.victim_dirty(victim_dirty),
		.victim_addr(victim_addr),
		.victim_data(victim_data)
	);

	mem_latency_timer #(
		.MEM_LATENCY(MEM_LATENCY)
	) i_mem_latency_timer (
		.clock(clock),
		.reset(reset),
		.start(start),
		.done(done)
	);

	backing_mem #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) i_backing_mem (
		.clock(clock),
		.reset(reset),
		.mem_addr(mem_addr),
		.mem_write(mem_write),
		.mem_write_data(mem_write_data),
		.mem_read_data(mem_read_data)
	);

endmodule

//--- source/mem_latency_timer.sv
`timescale 1ns/100ps

module mem_latency_timer #(
	parameter MEM_LATENCY = 4
)(
	input			clock,
	input			reset,
	input			start,
	output logic	done
);

	localparam CNT_WIDTH = $clog2(MEM_LATENCY);

	logic					busy;
	logic [CNT_WIDTH-1:0]	count;

	// last cycle of the access
	assign done = busy && (count == '0);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			busy  <= 1'b0;
			count <= '0;
		end
		else if (!busy)
		begin
			// start is ignored while an access is running
			if (start)
			begin
				busy  <= 1'b1;
				count <= CNT_WIDTH'(MEM_LATENCY - 1);
			end
		end
		else if (count == '0)
		begin
			busy <= 1'b0;
		end
		else
		begin
			count <= count - 1'b1;
		end
	end

endmodule

//--- src.f
source/dcache_pkg.sv
source/dcache_mem.sv
source/dcache_controller.sv
source/mem_latency_timer.sv
source/backing_mem.sv
source/dcache_top.sv
tb/dcache_chk.sv
tb/dcache_monitor.sv
tb/dcache_tb.sv

//--- tb/dcache_chk.sv
`timescale 1ns/100ps

module dcache_chk (
	input							clock,
	input							reset,
	input dcache_pkg::ctrl_state_t	state,
	input							arready,
	input							awready,
	input							wready,
	input							rvalid,
	input							rready,
	input [31:0]					rdata,
	input							bvalid,
	input							bready
);

	int fail_count = 0;

	// read response held with its data until taken
	rvalid_hold: assert property (@(posedge clock) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata))
	else
	begin
		fail_count++;
		$error("rvalid dropped or rdata changed before rready");
	end

	bvalid_hold: assert property (@(posedge clock) disable iff (reset)
		bvalid && !bready |=> bvalid)
	else
	begin
		fail_count++;
		$error("bvalid dropped before bready");
	end

	// address channels only open in idle
	ready_in_idle: assert property (@(posedge clock) disable iff (reset)
		(arready || awready) |-> state == dcache_pkg::ST_IDLE)
	else
	begin
		fail_count++;
		$error("arready or awready high outside ST_IDLE");
	end

	quiet_after_reset: assert property (@(posedge clock)
		$fell(reset) |-> !arready && !awready && !wready && !rvalid && !bvalid)
	else
	begin
		fail_count++;
		$error("ready or valid output high right after reset");
	end

endmodule

bind dcache_controller dcache_chk i_dcache_chk (
	.clock(clock),
	.reset(reset),
	.state(state),
	.arready(arready),
	.awready(awready),
	.wready(wready),
	.rvalid(rvalid),
	.rready(rready),
	.rdata(rdata),
	.bvalid(bvalid),
	.bready(bready)
);

//--- tb/dcache_monitor.sv
`timescale 1ns/100ps

module dcache_monitor #(
	parameter ADDR_WIDTH = 12
)(
	input					clock,
	input					reset,
	input [ADDR_WIDTH-1:0]	awaddr,
	input					awvalid,
	input					awready,
	input [31:0]			wdata,
	input					wvalid,
	input					wready,
	input [1:0]				bresp,
	input					bvalid,
	input					bready,
	input [ADDR_WIDTH-1:0]	araddr,
	input					arvalid,
	input					arready,
	input [31:0]			rdata,
	input [1:0]				rresp,
	input					rvalid,
	input					rready,
	// read is known to hit so its latency is checked
	input					hit_expected,
	output int				error_count,
	output int				check_count
);

	localparam WORDS = 2 ** (ADDR_WIDTH - 2);

	logic [31:0]			ref_words [WORDS];
	logic [ADDR_WIDTH-1:0]	rd_addr;
	logic					rd_hit_check;
	logic					rd_waiting;
	logic					wr_misaligned;
	int						cycle;
	int						ar_cycle;

	// last word written or zero if never written
	function automatic void expected_read(input logic [ADDR_WIDTH-1:0] a,
		output logic [31:0] data, output logic [1:0] resp);
		if (a[1:0] != 2'b00)
		begin
			data = '0;
			resp = dcache_pkg::RESP_SLVERR;
		end
		else
		begin
			data = ref_words[a[ADDR_WIDTH-1:2]];
			resp = dcache_pkg::RESP_OKAY;
		end
	endfunction

	initial
	begin
		error_count = 0;
		check_count = 0;
	end

	always @(posedge clock)
	begin
		logic [31:0] exp_data;
		logic [1:0] exp_resp;
		if (reset)
		begin
			for (int i = 0; i < WORDS; i++)
				ref_words[i] = '0;
			rd_waiting = 1'b0;
			cycle = 0;
		end
		else
		begin
			cycle++;
			if (arvalid && arready)
			begin
				rd_addr = araddr;
				rd_hit_check = hit_expected;
				ar_cycle = cycle;
				rd_waiting = 1'b1;
			end
			if (awvalid && awready && wvalid && wready)
			begin
				wr_misaligned = (awaddr[1:0] != 2'b00);
				if (!wr_misaligned)
					ref_words[awaddr[ADDR_WIDTH-1:2]] = wdata;
			end
			// first cycle the read response shows up
			if (rd_waiting && rvalid)
			begin
				rd_waiting = 1'b0;
				if (rd_hit_check && (cycle - ar_cycle != 2))
				begin
					error_count++;
					$display("Error %0t: read hit at 0x%h answered after %0d cycles, expected 2",
						$time, rd_addr, cycle - ar_cycle);
				end
			end
			if (rvalid && rready)
			begin
				expected_read(rd_addr, exp_data, exp_resp);
				check_count++;
				if (rresp != exp_resp || (exp_resp == dcache_pkg::RESP_OKAY && rdata != exp_data))
				begin
					error_count++;
					$display("Error %0t: read 0x%h gave 0x%h resp %0d, expected 0x%h resp %0d",
						$time, rd_addr, rdata, rresp, exp_data, exp_resp);
				end
			end
			if (bvalid && bready)
			begin
				exp_resp = wr_misaligned ? dcache_pkg::RESP_SLVERR : dcache_pkg::RESP_OKAY;
				check_count++;
				if (bresp != exp_resp)
				begin
					error_count++;
					$display("Error %0t: write bresp %0d, expected %0d", $time, bresp, exp_resp);
				end
			end
		end
	end

endmodule

//--- tb/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb;

	localparam ADDR_WIDTH  = 12;
	localparam NUM_SETS    = 8;
	localparam MEM_LATENCY = 4;
	localparam NUM_RANDOM  = 200;
	// transactions in tests 1 to 5
	localparam NUM_DIRECTED = 22;
	// writeback plus refill, handshakes and room for stalls
	localparam WORST_OP_CYCLES = 2 * (MEM_LATENCY + 1) + 6 + 16;
	localparam CYCLE_LIMIT = (NUM_DIRECTED + NUM_RANDOM) * WORST_OP_CYCLES + 20;

	logic					clock;
	logic					reset;
	logic [ADDR_WIDTH-1:0]	awaddr;
	logic					awvalid;
	logic					awready;
	logic [31:0]			wdata;
	logic					wvalid;
	logic					wready;
	logic [1:0]				bresp;
	logic					bvalid;
	logic					bready;
	logic [ADDR_WIDTH-1:0]	araddr;
	logic					arvalid;
	logic					arready;
	logic [31:0]			rdata;
	logic [1:0]				rresp;
	logic					rvalid;
	logic					rready;
	logic					hit_expected;
	int						error_count;
	int						check_count;
	int						cycles;
	logic [15:0]			lfsr_state = 16'd57719;

	dcache_top #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.NUM_SETS(NUM_SETS),
		.MEM_LATENCY(MEM_LATENCY)
	) i_dcache_top (
		.clock(clock),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready)
	);

	dcache_monitor #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) i_dcache_monitor (
		.clock(clock),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.hit_expected(hit_expected),
		.error_count(error_count),
		.check_count(check_count)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// taps of x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] bits;
		logic feedback;
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			feedback = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], feedback};
			bits = {bits[30:0], feedback};
		end
		return bits;
	endfunction

	// ready about three cycles in four when stalling
	function automatic logic ready_bit(input logic stalls);
		if (!stalls)
			return 1'b1;
		return take_bits(2) != 0;
	endfunction

	function automatic int total_errors();
		return error_count + i_dcache_top.i_dcache_controller.i_dcache_chk.fail_count;
	endfunction

	task automatic read_word(input logic [ADDR_WIDTH-1:0] a, input logic hit_check,
		input logic stalls);
		araddr <= a;
		arvalid <= 1'b1;
		hit_expected <= hit_check;
		do
			@(posedge clock);
		while (!arready);
		arvalid <= 1'b0;
		rready <= ready_bit(stalls);
		@(posedge clock);
		while (!(rvalid && rready))
		begin
			rready <= ready_bit(stalls);
			@(posedge clock);
		end
		rready <= 1'b0;
		hit_expected <= 1'b0;
	endtask

	task automatic write_word(input logic [ADDR_WIDTH-1:0] a, input logic [31:0] d,
		input logic stalls);
		awaddr <= a;
		wdata <= d;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		do
			@(posedge clock);
		while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		bready <= ready_bit(stalls);
		@(posedge clock);
		while (!(bvalid && bready))
		begin
			bready <= ready_bit(stalls);
			@(posedge clock);
		end
		bready <= 1'b0;
	endtask

	task automatic report_test(input int num, input string name, input int errs_before);
		// idle cycle so the last response is counted
		@(posedge clock);
		$display("test %0d (%s) finished with %0d errors", num, name,
			total_errors() - errs_before);
	endtask

	// hang guard
	initial
	begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout: no response from the DUT within %0d cycles, run stopped", cycles);
		$display("tests failed");
		$finish;
	end

	initial
	begin
		int errs_before;
		logic [ADDR_WIDTH-1:0] rand_addr;
		logic [31:0] rand_data;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		hit_expected = 1'b0;
		reset = 1'b1;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);

		errs_before = total_errors();
		read_word(12'h000, 1'b0, 1'b0);
		read_word(12'h104, 1'b0, 1'b0);
		read_word(12'h3fc, 1'b0, 1'b0);
		read_word(12'h250, 1'b0, 1'b0);
		report_test(1, "unwritten reads", errs_before);

		errs_before = total_errors();
		write_word(12'h040, 32'hdeadbeef, 1'b0);
		read_word(12'h040, 1'b0, 1'b0);
		read_word(12'h040, 1'b1, 1'b0);
		report_test(2, "write then read", errs_before);

		// three tags in set 3
		errs_before = total_errors();
		write_word(12'h00c, 32'h0000aaaa, 1'b0);
		write_word(12'h02c, 32'h0000bbbb, 1'b0);
		write_word(12'h04c, 32'h0000cccc, 1'b0);
		read_word(12'h00c, 1'b0, 1'b0);
		read_word(12'h02c, 1'b0, 1'b0);
		read_word(12'h04c, 1'b0, 1'b0);
		report_test(3, "conflict eviction", errs_before);

		// A, B, C all in set 5
		errs_before = total_errors();
		write_word(12'h014, 32'h1111aaaa, 1'b0);
		write_word(12'h034, 32'h2222bbbb, 1'b0);
		read_word(12'h014, 1'b1, 1'b0);
		write_word(12'h054, 32'h3333cccc, 1'b0);
		read_word(12'h014, 1'b1, 1'b0);
		read_word(12'h034, 1'b0, 1'b0);
		report_test(4, "lru replacement", errs_before);

		errs_before = total_errors();
		read_word(12'h041, 1'b0, 1'b0);
		write_word(12'h042, 32'h12345678, 1'b0);
		read_word(12'h040, 1'b1, 1'b0);
		report_test(5, "misaligned access", errs_before);

		// 64 words with eight tags per set
		errs_before = total_errors();
		for (int i = 0; i < NUM_RANDOM; i++)
		begin
			rand_addr = ADDR_WIDTH'(take_bits(6) << 2);
			if (take_bits(1))
			begin
				rand_data = take_bits(32);
				write_word(rand_addr, rand_data, 1'b1);
			end
			else
			begin
				read_word(rand_addr, 1'b0, 1'b1);
			end
		end
		report_test(6, "random traffic", errs_before);

		repeat (4) @(posedge clock);
		$display("%0d checks, %0d errors", check_count, total_errors());
		if (total_errors() == 0 && check_count > 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
